// ==== source/mem_path_pkg.sv ====
package mem_path_pkg;

   ////////////////////
   // Widths

   // Data and address width
   localparam int DATA_W = 32;

   // Destination register index
   localparam int REG_ADDR_W = 5;

   // Byte lanes per data word
   localparam int LANES = 4;

   // Byte width, used for lane shifts
   localparam int BYTE_W = 8;

   ////////////////////
   // Address constants

   // Low address bits that select a byte lane
   localparam int ADDR_LO_W = 2;

   ////////////////////
   // Access size

   typedef enum logic [1:0]
   {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   ////////////////////
   // Stage slots

   // Execute slot, holds the decoded request and its operands
   typedef struct packed
   {
      logic                  valid;
      logic                  load;
      logic                  store;
      logic                  lr;
      logic                  lr_wait;
      access_size_e          size;
      logic                  is_unsigned;
      logic [REG_ADDR_W-1:0] rd;
      logic [DATA_W-1:0]     base;
      logic [DATA_W-1:0]     offset;
      logic [DATA_W-1:0]     data;
   } exe_slot_t;

   // Memory slot
   // Valid means the slot holds a memory op; load covers LR.W too
   typedef struct packed
   {
      logic                  valid;
      logic                  load;
      access_size_e          size;
      logic                  is_unsigned;
      logic [REG_ADDR_W-1:0] rd;
      logic [ADDR_LO_W-1:0]  addr_lo;
   } mem_slot_t;

endpackage

// ==== source/dmem_if.sv ====
`timescale 1ns/1ps

interface dmem_if;

   // Request side, driven from execute
   logic                               req_valid;
   logic                               wen;
   logic [mem_path_pkg::DATA_W-1:0]    addr;
   logic [mem_path_pkg::DATA_W-1:0]    wdata;
   logic [mem_path_pkg::LANES-1:0]     mask;

   // Memory takes the request
   logic                               req_yumi;

   // Return side
   logic                               ret_valid;
   logic [mem_path_pkg::DATA_W-1:0]    rdata;

   // Pipe takes the returned data
   logic                               ret_yumi;

   // Address, write data and lane mask
   modport exe_mp (output wen, addr, wdata, mask);

   // Request strobe plus the two valids it reacts to
   modport ctrl_mp (output req_valid, input req_yumi, ret_valid);

   // Data return toward the memory slot
   modport ret_mp (input ret_valid, rdata, output ret_yumi);

endinterface

// ==== source/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage
(
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  stall_i,
   input  logic                                  req_valid_i,
   input  logic                                  req_load_i,
   input  logic                                  req_store_i,
   input  logic                                  req_lr_i,
   input  logic                                  req_lr_wait_i,
   input  logic                                  req_unsigned_i,
   input  mem_path_pkg::access_size_e            req_size_i,
   input  logic [mem_path_pkg::REG_ADDR_W-1:0]   req_rd_i,
   input  logic [mem_path_pkg::DATA_W-1:0]       req_base_i,
   input  logic [mem_path_pkg::DATA_W-1:0]       req_offset_i,
   input  logic [mem_path_pkg::DATA_W-1:0]       req_data_i,
   dmem_if.exe_mp                                dmem,
   output mem_path_pkg::exe_slot_t               exe_o,
   output mem_path_pkg::mem_slot_t               to_mem_o
);

   mem_path_pkg::exe_slot_t                 exe_q;
   logic [mem_path_pkg::DATA_W-1:0]         addr;
   logic [mem_path_pkg::ADDR_LO_W-1:0]      lane;
   logic [mem_path_pkg::DATA_W-1:0]         store_data;
   logic [mem_path_pkg::LANES-1:0]          mask;
   logic                                    is_mem_op;

   ////////////////////
   // Execute slot

   // Only the valid bit needs a reset, the operands follow it
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         exe_q.valid <= 1'b0;
      end
      else if (!stall_i)
      begin
         // A low req_valid_i loads a bubble
         exe_q <= '{valid       : req_valid_i,
                    load        : req_load_i,
                    store       : req_store_i,
                    lr          : req_lr_i,
                    lr_wait     : req_lr_wait_i,
                    size        : req_size_i,
                    is_unsigned : req_unsigned_i,
                    rd          : req_rd_i,
                    base        : req_base_i,
                    offset      : req_offset_i,
                    data        : req_data_i};
      end
   end

   ////////////////////
   // Address and lanes

   // LR.W arrives with a zero offset, so one adder serves all ops
   assign addr = exe_q.base + exe_q.offset;
   assign lane = addr[mem_path_pkg::ADDR_LO_W-1:0];

   // Shift byte or half into its lane and mark the lanes written
   always_comb
   begin
      case (exe_q.size)
         mem_path_pkg::SIZE_BYTE:
         begin
            store_data = mem_path_pkg::DATA_W'(exe_q.data[7:0]) << {lane, 3'b000};
            mask       = {{(mem_path_pkg::LANES-1){1'b0}}, 1'b1} << lane;
         end
         mem_path_pkg::SIZE_HALF:
         begin
            store_data = mem_path_pkg::DATA_W'(exe_q.data[15:0]) << {lane, 3'b000};
            mask       = {{(mem_path_pkg::LANES-2){1'b0}}, 2'b11} << lane;
         end
         default:
         begin
            // Full word, all lanes
            store_data = exe_q.data;
            mask       = '1;
         end
      endcase
   end

   assign is_mem_op = exe_q.valid & (exe_q.load | exe_q.store | exe_q.lr);

   // Request fields toward memory
   assign dmem.wen   = exe_q.store;
   assign dmem.addr  = addr;
   assign dmem.wdata = store_data;
   assign dmem.mask  = mask;

   // Slot handed to stall control
   assign exe_o = exe_q;

   // Slot handed to the memory stage, LR.W travels as a load
   assign to_mem_o = '{valid       : is_mem_op,
                       load        : exe_q.load | exe_q.lr,
                       size        : exe_q.size,
                       is_unsigned : exe_q.is_unsigned,
                       rd          : exe_q.rd,
                       addr_lo     : lane};

   // Half accesses must stay inside one word
   assert property (@(posedge clk) disable iff (reset)
      (is_mem_op && exe_q.size == mem_path_pkg::SIZE_HALF) |-> (lane != 2'b11));

endmodule

// ==== source/stall_control.sv ====
`timescale 1ns/1ps

module stall_control
(
   input  logic                       hold_i,
   input  logic                       reservation_i,
   input  mem_path_pkg::exe_slot_t    exe_i,
   input  logic                       load_pending_i,
   dmem_if.ctrl_mp                    dmem,
   output logic                       stall_o,
   output logic                       reserve_o
);

   logic is_mem_op;
   logic is_lr;
   logic stall_lrw;
   logic stall_req;
   logic stall_load;

   ////////////////////
   // Execute slot decode

   assign is_mem_op = exe_i.valid & (exe_i.load | exe_i.store | exe_i.lr);
   assign is_lr     = exe_i.valid & exe_i.lr;

   // LR.W with the wait bit holds until the reservation clears
   assign stall_lrw = is_lr & exe_i.lr_wait & reservation_i;

   // Plain LR.W sets the reservation
   assign reserve_o = is_lr & ~exe_i.lr_wait;

   ////////////////////
   // Request strobe

   // No request goes out under hold or a blocked LR.W
   assign dmem.req_valid = is_mem_op & ~hold_i & ~stall_lrw;

   ////////////////////
   // Stall terms

   // Request not yet taken by memory
   assign stall_req = is_mem_op & ~dmem.req_yumi;

   // Memory slot load with nothing buffered and nothing on the return bus
   assign stall_load = load_pending_i & ~dmem.ret_valid;

   // One stall freezes execute, memory and write-back together
   assign stall_o = hold_i | stall_req | stall_load | stall_lrw;

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
(
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  stall_i,
   input  logic                                  hold_i,
   input  mem_path_pkg::mem_slot_t               from_exe_i,
   dmem_if.ret_mp                                dmem,
   output logic                                  load_pending_o,
   output logic                                  wb_valid_o,
   output logic [mem_path_pkg::REG_ADDR_W-1:0]   wb_rd_o,
   output logic [mem_path_pkg::DATA_W-1:0]       wb_data_o
);

   mem_path_pkg::mem_slot_t              mem_q;
   logic                                 buf_valid_q;
   logic [mem_path_pkg::DATA_W-1:0]      buf_data_q;
   logic                                 is_load;
   logic                                 buf_capture;
   logic [mem_path_pkg::DATA_W-1:0]      loaded;
   logic [7:0]                           ld_byte;
   logic [15:0]                          ld_half;
   logic [mem_path_pkg::DATA_W-1:0]      ld_result;
   logic                                 wb_valid_q;
   logic [mem_path_pkg::REG_ADDR_W-1:0]  wb_rd_q;
   logic [mem_path_pkg::DATA_W-1:0]      wb_data_q;

   ////////////////////
   // Memory slot

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mem_q.valid <= 1'b0;
      end
      else if (!stall_i)
      begin
         mem_q <= from_exe_i;
      end
   end

   assign is_load = mem_q.valid & mem_q.load;

   // Returned data is taken whenever the slot holds a memory op
   assign dmem.ret_yumi = mem_q.valid & dmem.ret_valid;

   // Load still owed its data, stall control adds the live return
   assign load_pending_o = is_load & ~buf_valid_q;

   ////////////////////
   // Load buffer

   // Data that lands while the pipe is frozen is parked here
   // Hold is the usual case, any other stall term parks it too
   assign buf_capture = is_load & dmem.ret_valid & stall_i & ~buf_valid_q;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         buf_valid_q <= 1'b0;
      end
      else if (buf_capture)
      begin
         buf_valid_q <= 1'b1;
      end
      else if (!stall_i)
      begin
         // Slot moves on, buffer is spent
         buf_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (buf_capture)
      begin
         buf_data_q <= dmem.rdata;
      end
   end

   ////////////////////
   // Load extraction

   assign loaded  = buf_valid_q ? buf_data_q : dmem.rdata;
   assign ld_byte = loaded[{mem_q.addr_lo, 3'b000} +: 8];

   // Half sits in the upper or lower 16 bits
   assign ld_half = mem_q.addr_lo[1] ? loaded[31:16] : loaded[15:0];

   always_comb
   begin
      case (mem_q.size)
         mem_path_pkg::SIZE_BYTE:
            ld_result = mem_q.is_unsigned ? mem_path_pkg::DATA_W'(ld_byte)
                                          : {{24{ld_byte[7]}}, ld_byte};
         mem_path_pkg::SIZE_HALF:
            ld_result = mem_q.is_unsigned ? mem_path_pkg::DATA_W'(ld_half)
                                          : {{16{ld_half[15]}}, ld_half};
         default:
            ld_result = loaded;
      endcase
   end

   ////////////////////
   // Write-back slot

   // Strobe lasts one cycle, a stall holds it low
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_valid_q <= 1'b0;
      end
      else
      begin
         wb_valid_q <= is_load & ~stall_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall_i)
      begin
         wb_rd_q   <= mem_q.rd;
         wb_data_q <= ld_result;
      end
   end

   assign wb_valid_o = wb_valid_q;
   assign wb_rd_o    = wb_rd_q;
   assign wb_data_o  = wb_data_q;

   // Second return before the buffer drains would be lost
   assert property (@(posedge clk) disable iff (reset)
      buf_valid_q |-> !dmem.ret_valid);

   // Load data arriving under hold is parked in the buffer
   assert property (@(posedge clk) disable iff (reset)
      (hold_i && is_load && dmem.ret_valid && !buf_valid_q) |=> buf_valid_q);

endmodule

// ==== source/mem_path_top.sv ====
`timescale 1ns/1ps

module mem_path_top
(
   input  logic                                  clk,
   input  logic                                  reset,

   // Decoded request from execute
   input  logic                                  req_valid_i,
   input  logic                                  req_load_i,
   input  logic                                  req_store_i,
   input  logic                                  req_lr_i,
   input  logic                                  req_lr_wait_i,
   input  logic                                  req_unsigned_i,
   input  mem_path_pkg::access_size_e            req_size_i,
   input  logic [mem_path_pkg::REG_ADDR_W-1:0]   req_rd_i,
   input  logic [mem_path_pkg::DATA_W-1:0]       req_base_i,
   input  logic [mem_path_pkg::DATA_W-1:0]       req_offset_i,
   input  logic [mem_path_pkg::DATA_W-1:0]       req_data_i,

   // External stall and reservation state
   input  logic                                  hold_i,
   input  logic                                  reservation_i,

   // Data memory
   output logic                                  mem_valid_o,
   output logic                                  mem_wen_o,
   output logic [mem_path_pkg::DATA_W-1:0]       mem_addr_o,
   output logic [mem_path_pkg::DATA_W-1:0]       mem_data_o,
   output logic [mem_path_pkg::LANES-1:0]        mem_mask_o,
   input  logic                                  mem_yumi_i,
   input  logic                                  mem_valid_i,
   input  logic [mem_path_pkg::DATA_W-1:0]       mem_data_i,
   output logic                                  mem_yumi_o,

   // Pipe status and write-back
   output logic                                  stall_o,
   output logic                                  reserve_o,
   output logic                                  wb_valid_o,
   output logic [mem_path_pkg::REG_ADDR_W-1:0]   wb_rd_o,
   output logic [mem_path_pkg::DATA_W-1:0]       wb_data_o
);

   mem_path_pkg::exe_slot_t   exe_slot;
   mem_path_pkg::mem_slot_t   mem_slot;
   logic                      stall;
   logic                      load_pending;

   dmem_if dmem ();

   ////////////////////
   // Memory ports

   assign mem_valid_o    = dmem.req_valid;
   assign mem_wen_o      = dmem.wen;
   assign mem_addr_o     = dmem.addr;
   assign mem_data_o     = dmem.wdata;
   assign mem_mask_o     = dmem.mask;
   assign dmem.req_yumi  = mem_yumi_i;
   assign dmem.ret_valid = mem_valid_i;
   assign dmem.rdata     = mem_data_i;
   assign mem_yumi_o     = dmem.ret_yumi;

   assign stall_o = stall;

   ////////////////////
   // Stages

   exe_stage exe_u
   (
      .clk            (clk),
      .reset          (reset),
      .stall_i        (stall),
      .req_valid_i    (req_valid_i),
      .req_load_i     (req_load_i),
      .req_store_i    (req_store_i),
      .req_lr_i       (req_lr_i),
      .req_lr_wait_i  (req_lr_wait_i),
      .req_unsigned_i (req_unsigned_i),
      .req_size_i     (req_size_i),
      .req_rd_i       (req_rd_i),
      .req_base_i     (req_base_i),
      .req_offset_i   (req_offset_i),
      .req_data_i     (req_data_i),
      .dmem           (dmem),
      .exe_o          (exe_slot),
      .to_mem_o       (mem_slot)
   );

   stall_control stall_u
   (
      .hold_i         (hold_i),
      .reservation_i  (reservation_i),
      .exe_i          (exe_slot),
      .load_pending_i (load_pending),
      .dmem           (dmem),
      .stall_o        (stall),
      .reserve_o      (reserve_o)
   );

   mem_stage mem_u
   (
      .clk            (clk),
      .reset          (reset),
      .stall_i        (stall),
      .hold_i         (hold_i),
      .from_exe_i     (mem_slot),
      .dmem           (dmem),
      .load_pending_o (load_pending),
      .wb_valid_o     (wb_valid_o),
      .wb_rd_o        (wb_rd_o),
      .wb_data_o      (wb_data_o)
   );

endmodule

// ==== dv/mem_path_tb.sv ====
`timescale 1ns/1ps

module mem_path_tb;

   // Run length and cycle limit
   localparam int NUM_REQS = 2000;
   localparam int MAX_CYC  = 12 * NUM_REQS;

   logic                                  clk;
   logic                                  reset;
   logic                                  req_valid_i, req_load_i, req_store_i, req_lr_i;
   logic                                  req_lr_wait_i, req_unsigned_i;
   mem_path_pkg::access_size_e            req_size_i;
   logic [mem_path_pkg::REG_ADDR_W-1:0]   req_rd_i;
   logic [mem_path_pkg::DATA_W-1:0]       req_base_i, req_offset_i, req_data_i;
   logic                                  hold_i, reservation_i;
   logic                                  mem_valid_o, mem_wen_o, mem_yumi_i, mem_valid_i;
   logic [mem_path_pkg::DATA_W-1:0]       mem_addr_o, mem_data_o, mem_data_i;
   logic [mem_path_pkg::LANES-1:0]        mem_mask_o;
   logic                                  mem_yumi_o, stall_o, reserve_o, wb_valid_o;
   logic [mem_path_pkg::REG_ADDR_W-1:0]   wb_rd_o;
   logic [mem_path_pkg::DATA_W-1:0]       wb_data_o;

   // Model state
   logic [31:0]                mem_model [256];
   logic [31:0]                rng;
   mem_path_pkg::exe_slot_t    cur_req;
   mem_path_pkg::exe_slot_t    exe_model;
   logic [36:0]                exp_q [$];
   logic [36:0]                exp_wb;
   logic                       ret_pending;
   logic                       ret_fire;
   logic [1:0]                 ret_delay;
   logic [31:0]                ret_word;
   logic [31:0]                addr;
   logic [31:0]                exp_word;
   logic [3:0]                 exp_mask;
   logic                       exp_reserve;
   logic                       exp_stall;
   logic                       mem_load_m;
   logic                       mem_got_m;
   logic [31:0]                r;
   logic                       done;
   int                         cycle, reset_edges, issued, idle;
   int                         n_loads, n_stores, hold_returns, err_value, err_other;

   mem_path_top dut_i (.*);

   ////////////////////
   // Helpers

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   // Lanes written by a store at this address
   function automatic logic [3:0] store_mask(input mem_path_pkg::access_size_e size,
                                             input logic [1:0] lo);
      case (size)
         mem_path_pkg::SIZE_BYTE: return 4'b0001 << lo;
         mem_path_pkg::SIZE_HALF: return 4'b0011 << lo;
         default: return 4'b1111;
      endcase
   endfunction

   // Source bytes land on the masked lanes, the rest stays zero
   function automatic logic [31:0] store_lanes(input logic [3:0] mask, input logic [1:0] lo,
                                               input logic [31:0] data);
      logic [31:0] res;
      res = '0;
      for (int i = 0; i < 4; i++)
      begin
         if (mask[i])
            res[8*i +: 8] = data[8*(i - lo) +: 8];
      end
      return res;
   endfunction

   // Value a load writes back from the addressed word
   function automatic logic [31:0] load_value(input logic [31:0] word,
                                              input mem_path_pkg::access_size_e size,
                                              input logic uns, input logic [1:0] lo);
      logic [31:0] sh;
      sh = word >> (8 * lo);
      case (size)
         mem_path_pkg::SIZE_BYTE: return uns ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
         mem_path_pkg::SIZE_HALF: return uns ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
         default: return word;
      endcase
   endfunction

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
      $display("** Error: %s expected 0x%h, got 0x%h at cycle %0d", name, exp, got, cycle);
      err_value++;
   endtask

   task automatic report_fault(input string msg);
      $display("** Error: %s at cycle %0d", msg, cycle);
      err_other++;
   endtask

   task automatic print_counts();
      $display("Loads %0d, stores %0d, returns under hold %0d, value errors %0d, other errors %0d",
               n_loads, n_stores, hold_returns, err_value, err_other);
   endtask

   // Draw the next request and put it on the inputs
   task automatic make_request();
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [1:0]  lo;
      int          kind;
      r0 = next_rand();
      r1 = next_rand();
      r2 = next_rand();
      kind = int'(r0[15:8]) % 10;
      cur_req = '0;
      cur_req.valid = (issued < NUM_REQS) && (r0[2:0] != 3'd0);
      cur_req.lr = (kind == 0);
      cur_req.load = (kind >= 1) && (kind <= 5);
      cur_req.store = (kind >= 6);
      cur_req.lr_wait = cur_req.lr & r0[16];
      cur_req.size = cur_req.lr ? mem_path_pkg::SIZE_WORD
                                : mem_path_pkg::access_size_e'(2'((r0 >> 17) % 3));
      cur_req.is_unsigned = ~cur_req.lr & r0[19];
      cur_req.rd = r0[24:20];
      // Aligned address, LR.W has no offset
      case (cur_req.size)
         mem_path_pkg::SIZE_BYTE: lo = r1[1:0];
         mem_path_pkg::SIZE_HALF: lo = {r1[1], 1'b0};
         default: lo = 2'b00;
      endcase
      cur_req.offset = cur_req.lr ? 32'h0 : {{20{r2[11]}}, r2[11:0]};
      cur_req.base = {r1[31:2], lo} - cur_req.offset;
      cur_req.data = next_rand();
      req_valid_i    <= cur_req.valid;
      req_load_i     <= cur_req.load;
      req_store_i    <= cur_req.store;
      req_lr_i       <= cur_req.lr;
      req_lr_wait_i  <= cur_req.lr_wait;
      req_unsigned_i <= cur_req.is_unsigned;
      req_size_i     <= cur_req.size;
      req_rd_i       <= cur_req.rd;
      req_base_i     <= cur_req.base;
      req_offset_i   <= cur_req.offset;
      req_data_i     <= cur_req.data;
   endtask

   ////////////////////
   // Clock and reset

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;
      end
   end

   initial
   begin
      reset = 1'b1;
      {req_valid_i, req_load_i, req_store_i, req_lr_i, req_lr_wait_i, req_unsigned_i} = '0;
      req_size_i = mem_path_pkg::SIZE_BYTE;
      req_rd_i = '0;
      req_base_i = '0;
      req_offset_i = '0;
      req_data_i = '0;
      {hold_i, reservation_i, mem_yumi_i, mem_valid_i} = '0;
      mem_data_i = '0;
      rng = 32'd70189;
      cur_req = '0;
      exe_model = '0;
      ret_pending = 1'b0;
      ret_delay = '0;
      ret_word = '0;
      mem_load_m = 1'b0;
      mem_got_m = 1'b0;
      done = 1'b0;
      {cycle, reset_edges, issued, idle} = '0;
      {n_loads, n_stores, hold_returns, err_value, err_other} = '0;
      // Every word differs and depends on all index bits
      for (int i = 0; i < 256; i++)
      begin
         mem_model[i] = {8'(i), 8'(~i), 8'(i * 37 + 11), 8'(i ^ 8'h5a)};
      end
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      wait (done);
      if (exp_q.size() != 0)
         report_fault("loads still waiting for write-back when the run ended");
      if (hold_returns == 0)
         report_fault("no load data came back while hold_i was high");
      print_counts();
      if (err_value + err_other == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   ////////////////////
   // Memory model and checks

   always @(posedge clk)
   begin
      if (reset)
      begin
         // Outputs must be low once the first reset edge has passed
         if (reset_edges > 0 && (mem_valid_o || mem_yumi_o || wb_valid_o || reserve_o))
            report_fault("an output is high during reset");
         reset_edges++;
      end
      else if (!done)
      begin
         cycle++;
         if (cycle > MAX_CYC)
         begin
            $display("Timeout after %0d cycles, %0d of %0d requests taken",
                     cycle, issued, NUM_REQS);
            print_counts();
            $display("Finished with errors");
            $finish;
         end
         else
         begin
            if (cycle == 1 && (mem_valid_o || mem_yumi_o || wb_valid_o || reserve_o))
               report_fault("an output is high right after reset");

            // LR.W reservation and the wait block
            exp_reserve = exe_model.valid & exe_model.lr & ~exe_model.lr_wait;
            if (reserve_o !== exp_reserve)
               report_value("reserve_o", 32'(exp_reserve), 32'(reserve_o));
            if (mem_valid_o && exe_model.valid && exe_model.lr && exe_model.lr_wait
                && reservation_i)
               report_fault("LR.W with wait bit issued while the reservation is held");
            if (mem_valid_o && hold_i)
               report_fault("mem_valid_o raised while hold_i is high");

            // Stall from hold, pending request, owed load data and LR.W wait
            exp_stall = hold_i
                        | (exe_model.valid & (exe_model.load | exe_model.store | exe_model.lr)
                           & ~mem_yumi_i)
                        | (exe_model.valid & exe_model.lr & exe_model.lr_wait & reservation_i)
                        | (mem_load_m & ~mem_got_m & ~mem_valid_i);
            if (stall_o !== exp_stall)
               report_value("stall_o", 32'(exp_stall), 32'(stall_o));

            // Write-back in load order
            if (wb_valid_o)
            begin
               if (exp_q.size() == 0)
               begin
                  report_fault("write-back appeared with no load outstanding");
               end
               else
               begin
                  exp_wb = exp_q.pop_front();
                  if (wb_rd_o !== exp_wb[36:32])
                     report_value("wb_rd_o", 32'(exp_wb[36:32]), 32'(wb_rd_o));
                  if (wb_data_o !== exp_wb[31:0])
                     report_value("wb_data_o", exp_wb[31:0], wb_data_o);
               end
            end

            // Returned data is always taken
            if (mem_valid_i)
            begin
               if (!mem_yumi_o)
                  report_fault("returned load data was not taken");
               if (hold_i)
                  hold_returns++;
            end

            // Accepted request
            if (mem_valid_o && mem_yumi_i)
            begin
               addr = exe_model.base + exe_model.offset;
               if (!exe_model.valid || !(exe_model.load || exe_model.store || exe_model.lr))
                  report_fault("request issued with no memory op in execute");
               if (stall_o)
                  report_fault("request accepted while the execute slot is stalled");
               if (mem_addr_o !== addr)
                  report_value("mem_addr_o", addr, mem_addr_o);
               if (mem_wen_o !== exe_model.store)
                  report_value("mem_wen_o", 32'(exe_model.store), 32'(mem_wen_o));
               if (exe_model.store)
               begin
                  exp_mask = store_mask(exe_model.size, addr[1:0]);
                  exp_word = store_lanes(exp_mask, addr[1:0], exe_model.data);
                  if (mem_mask_o !== exp_mask)
                     report_value("mem_mask_o", 32'(exp_mask), 32'(mem_mask_o));
                  if (mem_data_o !== exp_word)
                     report_value("mem_data_o", exp_word, mem_data_o);
                  for (int i = 0; i < 4; i++)
                  begin
                     if (exp_mask[i])
                        mem_model[addr[9:2]][8*i +: 8] = exp_word[8*i +: 8];
                  end
                  n_stores++;
               end
               else
               begin
                  // Load or LR.W, data comes back 0 to 3 cycles later
                  ret_word = mem_model[addr[9:2]];
                  exp_q.push_back({exe_model.rd, load_value(ret_word, exe_model.size,
                                                            exe_model.is_unsigned, addr[1:0])});
                  ret_pending = 1'b1;
                  r = next_rand();
                  ret_delay = r[1:0];
                  n_loads++;
               end
            end

            // Memory slot follows the pipe
            if (!stall_o)
            begin
               mem_load_m = exe_model.valid & (exe_model.load | exe_model.lr);
               mem_got_m = 1'b0;
            end
            else if (mem_load_m && mem_valid_i)
            begin
               mem_got_m = 1'b1;
            end

            // Execute slot follows the pipe
            if (!stall_o)
            begin
               exe_model = cur_req;
               if (cur_req.valid)
                  issued++;
               make_request();
            end

            // Return timing for the next cycle
            ret_fire = 1'b0;
            if (ret_pending)
            begin
               if (ret_delay == 2'd0)
               begin
                  ret_fire = 1'b1;
                  ret_pending = 1'b0;
               end
               else
               begin
                  ret_delay--;
               end
            end
            r = next_rand();
            mem_valid_i   <= ret_fire;
            mem_data_i    <= ret_fire ? ret_word : r;
            // One access at a time, new accept only once the return is due
            mem_yumi_i    <= !ret_pending && (r[9:8] != 2'b00);
            hold_i        <= (r[14:12] == 3'd0);
            reservation_i <= (r[17:16] == 2'b00);

            // Drain before ending
            if (issued == NUM_REQS && !exe_model.valid && !ret_pending)
            begin
               idle++;
               if (idle >= 8)
                  done = 1'b1;
            end
         end
      end
   end

endmodule

// ==== list.f ====
source/mem_path_pkg.sv
source/dmem_if.sv
source/exe_stage.sv
source/stall_control.sv
source/mem_stage.sv
source/mem_path_top.sv
dv/mem_path_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the memory path testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module mem_path_tb -f list.f \
   && ./obj_dir/Vmem_path_tb | tee sim.log \
   || { echo "Build or simulation did not complete"; exit 1; }
grep -q "Finished with errors" sim.log && exit 1 || exit 0
